/* cpu_pkg.sv */
package cpu_pkg;

    localparam int instr_width    = 16;
    localparam int reg_addr_width = 3;

    typedef logic [reg_addr_width-1:0] reg_addr_t;

    localparam reg_addr_t ra_addr = 3'd0;
    localparam reg_addr_t rb_addr = 3'd1;
    localparam reg_addr_t rc_addr = 3'd2;
    localparam reg_addr_t sp_addr = 3'd3;
    localparam reg_addr_t xa_addr = 3'd4;
    localparam reg_addr_t xb_addr = 3'd5;
    localparam reg_addr_t ba_addr = 3'd6;
    localparam reg_addr_t bb_addr = 3'd7;

    // Instruction field positions.
    // Inside a field the lowest word bit is the msb of the field value,
    // so rg = {instr[10], instr[11], instr[12]} and code bit 0 is instr[0].
    localparam int code_lsb = 0;     // 7 code bits
    localparam int d_bit    = 7;     // direction
    localparam int mode_lsb = 8;     // 2 mode bits
    localparam int rg_lsb   = 10;
    localparam int rm_lsb   = 13;

    localparam logic [1:0] mode_reg = 2'b11;    // register direct

    typedef enum logic [3:0] {
        op_add,
        op_adc,
        op_sub,
        op_sbb,
        op_neg,
        op_and,
        op_or,
        op_xor,
        op_not,
        op_shl,
        op_shr,
        op_sar,
        op_inc,
        op_dec,
        op_pass_a,      // operand a unchanged
        op_pass_io      // io input port
    } alu_op_t;

    typedef struct packed {
        logic sign;     // bit 2
        logic zero;     // bit 1
        logic carry;    // bit 0
    } flags_t;

    function automatic logic flag_writing(alu_op_t op);
        return !(op inside {op_pass_a, op_pass_io});
    endfunction

endpackage

/* instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
    input  wire                                  i_w_clk,
    input  wire                                  i_w_reset,
    input  wire                                  i_w_instr_req,
    input  wire [cpu_pkg::instr_width-1:0]       i_w_instr,
    input  wire                                  i_w_retire,
    output logic                                 o_w_instr_ack,
    output logic                                 o_w_issue,
    output cpu_pkg::alu_op_t                     o_w_alu_op,
    output cpu_pkg::reg_addr_t                   o_w_rd_addr_a,
    output cpu_pkg::reg_addr_t                   o_w_rd_addr_b,
    output logic                                 o_w_wr_en,
    output cpu_pkg::reg_addr_t                   o_w_wr_addr,
    output logic                                 o_w_illegal,
    output logic                                 o_w_out
);

    import cpu_pkg::*;

    typedef enum logic [1:0] {
        l_p_st_idle,
        l_p_st_ack,
        l_p_st_issue,
        l_p_st_busy
    } l_t_state;

    l_t_state                   l_r_state;
    logic                       l_r_ack;
    logic [instr_width-1:0]     l_r_instr;       // held until retire
    logic [0:6]                 l_w_cop;
    logic                       l_w_d;
    logic [0:1]                 l_w_mode;
    logic [0:reg_addr_width-1]  l_w_rg;
    logic [0:reg_addr_width-1]  l_w_rm;
    logic                       l_w_sel_ok;
    logic                       l_w_one_op;
    logic                       l_w_two_op;
    logic                       l_w_io;

    always_ff @(posedge i_w_clk or negedge i_w_reset) begin
        if (!i_w_reset) begin
            l_r_state <= l_p_st_idle;
            l_r_ack   <= 1'b0;
            l_r_instr <= '0;
        end else begin
            if (l_r_state == l_p_st_idle && i_w_instr_req && !l_r_ack) begin
                l_r_ack   <= 1'b1;
                l_r_instr <= i_w_instr;              // capture on the accepting edge
            end else if (l_r_ack && !i_w_instr_req) begin
                l_r_ack <= 1'b0;
            end
            case (l_r_state)
                l_p_st_idle: begin
                    if (i_w_instr_req && !l_r_ack) begin
                        l_r_state <= l_p_st_ack;
                    end
                end
                l_p_st_ack:   l_r_state <= l_p_st_issue;
                l_p_st_issue: l_r_state <= l_p_st_busy;
                default: begin
                    if (i_w_retire) begin
                        l_r_state <= l_p_st_idle;
                    end
                end
            endcase
        end
    end

    assign o_w_instr_ack = l_r_ack;
    assign o_w_issue     = (l_r_state == l_p_st_issue);

    // pull fields out, lowest word bit first
    always_comb begin
        for (int i = 0; i < 7; i++) begin
            l_w_cop[i] = l_r_instr[code_lsb + i];
        end
        for (int i = 0; i < 2; i++) begin
            l_w_mode[i] = l_r_instr[mode_lsb + i];
        end
        for (int i = 0; i < reg_addr_width; i++) begin
            l_w_rg[i] = l_r_instr[rg_lsb + i];
            l_w_rm[i] = l_r_instr[rm_lsb + i];
        end
    end

    assign l_w_d      = l_r_instr[d_bit];
    assign l_w_sel_ok = (l_w_cop[4:6] != 3'b111);
    assign l_w_one_op = (l_w_cop[0:3] == 4'b0001) && (l_w_mode == mode_reg) && l_w_sel_ok;
    assign l_w_two_op = (l_w_cop[0:2] == 3'b010) && (l_w_mode == mode_reg) && l_w_sel_ok;
    assign l_w_io     = (l_w_cop[0:5] == 6'b100000);

    always_comb begin
        o_w_alu_op    = op_pass_a;                   // illegal reports RA, writes nothing
        o_w_rd_addr_a = ra_addr;
        o_w_rd_addr_b = ra_addr;
        o_w_wr_en     = 1'b0;
        o_w_wr_addr   = ra_addr;
        o_w_illegal   = 1'b1;
        o_w_out       = 1'b0;
        if (l_w_one_op) begin
            o_w_illegal   = 1'b0;
            o_w_rd_addr_a = l_w_rm;
            o_w_wr_en     = 1'b1;
            o_w_wr_addr   = l_w_rm;
            case (l_w_cop[4:6])
                3'b000:  o_w_alu_op = op_inc;
                3'b001:  o_w_alu_op = op_dec;
                3'b010:  o_w_alu_op = op_neg;
                3'b011:  o_w_alu_op = op_not;
                3'b100:  o_w_alu_op = op_shl;
                3'b101:  o_w_alu_op = op_shr;
                3'b110:  o_w_alu_op = op_sar;
                default: o_w_alu_op = op_pass_a;
            endcase
        end else if (l_w_two_op) begin
            o_w_illegal   = 1'b0;
            o_w_rd_addr_a = l_w_d ? l_w_rg : l_w_rm;     // destination
            o_w_rd_addr_b = l_w_d ? l_w_rm : l_w_rg;     // source
            o_w_wr_en     = l_w_cop[3];                  // low for cmp/test
            o_w_wr_addr   = l_w_d ? l_w_rg : l_w_rm;
            case (l_w_cop[4:6])
                3'b000:  o_w_alu_op = op_add;
                3'b001:  o_w_alu_op = op_adc;
                3'b010:  o_w_alu_op = op_sub;
                3'b011:  o_w_alu_op = op_sbb;
                3'b100:  o_w_alu_op = op_and;
                3'b101:  o_w_alu_op = op_or;
                3'b110:  o_w_alu_op = op_xor;
                default: o_w_alu_op = op_pass_a;
            endcase
        end else if (l_w_io) begin
            o_w_illegal = 1'b0;
            if (!l_w_cop[6]) begin                       // IN
                o_w_alu_op = op_pass_io;
                o_w_wr_en  = 1'b1;
            end else begin                               // OUT, RA on port a
                o_w_out = 1'b1;
            end
        end
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter int p_data_width = 16
) (
    input  wire                         i_w_clk,
    input  wire                         i_w_reset,
    input  wire cpu_pkg::reg_addr_t     i_w_rd_addr_a,
    input  wire cpu_pkg::reg_addr_t     i_w_rd_addr_b,
    input  wire                         i_w_wr_en,
    input  wire cpu_pkg::reg_addr_t     i_w_wr_addr,
    input  wire [p_data_width-1:0]      i_w_wr_data,
    output logic [p_data_width-1:0]     o_w_rd_data_a,
    output logic [p_data_width-1:0]     o_w_rd_data_b
);

    import cpu_pkg::*;

    localparam int l_p_reg_count = 2 ** reg_addr_width;    // RA..BB

    logic [p_data_width-1:0] l_r_regs [l_p_reg_count];

    always_ff @(posedge i_w_clk or negedge i_w_reset) begin
        if (!i_w_reset) begin
            for (int i = 0; i < l_p_reg_count; i++) begin
                l_r_regs[i] <= '0;
            end
        end else if (i_w_wr_en) begin
            l_r_regs[i_w_wr_addr] <= i_w_wr_data;
        end
    end

    // both read ports see a write only after the edge
    assign o_w_rd_data_a = l_r_regs[i_w_rd_addr_a];
    assign o_w_rd_data_b = l_r_regs[i_w_rd_addr_b];

endmodule

/* alu_execute.sv */
`timescale 1ns/1ps

module alu_execute #(
    parameter int p_data_width = 16
) (
    input  wire                         i_w_clk,
    input  wire                         i_w_reset,
    input  wire                         i_w_issue,
    input  wire cpu_pkg::alu_op_t       i_w_alu_op,
    input  wire [p_data_width-1:0]      i_w_opd_a,
    input  wire [p_data_width-1:0]      i_w_opd_b,
    input  wire [p_data_width-1:0]      i_w_io_data,
    output logic                        o_w_done,
    output logic [p_data_width-1:0]     o_w_result,
    output cpu_pkg::flags_t             o_w_flags
);

    import cpu_pkg::*;

    localparam logic [p_data_width:0] l_p_one = {{p_data_width{1'b0}}, 1'b1};

    logic [p_data_width:0]  l_w_ext_a;
    logic [p_data_width:0]  l_w_ext_b;
    logic [p_data_width:0]  l_w_ext_c;
    logic [p_data_width:0]  l_w_wide;       // carry or borrow on top
    flags_t                 l_w_flags_next;
    flags_t                 l_r_flags;

    assign l_w_ext_a = {1'b0, i_w_opd_a};
    assign l_w_ext_b = {1'b0, i_w_opd_b};
    assign l_w_ext_c = {{p_data_width{1'b0}}, l_r_flags.carry};

    always_comb begin
        case (i_w_alu_op)
            op_add:     l_w_wide = l_w_ext_a + l_w_ext_b;
            op_adc:     l_w_wide = l_w_ext_a + l_w_ext_b + l_w_ext_c;
            op_sub:     l_w_wide = l_w_ext_a - l_w_ext_b;
            op_sbb:     l_w_wide = l_w_ext_a - l_w_ext_b - l_w_ext_c;
            op_inc:     l_w_wide = l_w_ext_a + l_p_one;
            op_dec:     l_w_wide = l_w_ext_a - l_p_one;
            op_neg:     l_w_wide = '0 - l_w_ext_a;      // borrow set for a != 0
            op_and:     l_w_wide = {1'b0, i_w_opd_a & i_w_opd_b};
            op_or:      l_w_wide = {1'b0, i_w_opd_a | i_w_opd_b};
            op_xor:     l_w_wide = {1'b0, i_w_opd_a ^ i_w_opd_b};
            op_not:     l_w_wide = {1'b0, ~i_w_opd_a};
            op_shl:     l_w_wide = {i_w_opd_a, 1'b0};   // msb falls into carry
            op_shr:     l_w_wide = {i_w_opd_a[0], 1'b0, i_w_opd_a[p_data_width-1:1]};
            op_sar: begin
                l_w_wide = {i_w_opd_a[0], i_w_opd_a[p_data_width-1],
                            i_w_opd_a[p_data_width-1:1]};
            end
            op_pass_io: l_w_wide = {1'b0, i_w_io_data};
            default:    l_w_wide = l_w_ext_a;           // pass_a
        endcase
    end

    always_comb begin
        l_w_flags_next.carry = l_w_wide[p_data_width];
        l_w_flags_next.zero  = (l_w_wide[p_data_width-1:0] == '0);
        l_w_flags_next.sign  = l_w_wide[p_data_width-1];
    end

    always_ff @(posedge i_w_clk or negedge i_w_reset) begin
        if (!i_w_reset) begin
            o_w_done  <= 1'b0;
            l_r_flags <= '0;
        end else begin
            o_w_done <= i_w_issue;                      // one cycle after issue
            if (i_w_issue && flag_writing(i_w_alu_op)) begin
                l_r_flags <= l_w_flags_next;
            end
        end
    end

    always_ff @(posedge i_w_clk) begin
        if (i_w_issue) begin
            o_w_result <= l_w_wide[p_data_width-1:0];
        end
    end

    assign o_w_flags = l_r_flags;

endmodule

/* result_writeback.sv */
`timescale 1ns/1ps

module result_writeback #(
    parameter int p_data_width = 16
) (
    input  wire                         i_w_clk,
    input  wire                         i_w_reset,
    input  wire                         i_w_done,
    input  wire [p_data_width-1:0]      i_w_result,
    input  wire cpu_pkg::flags_t        i_w_flags,
    input  wire                         i_w_wr_en,
    input  wire cpu_pkg::reg_addr_t     i_w_wr_addr,
    input  wire                         i_w_illegal,
    input  wire                         i_w_out,
    input  wire                         i_w_res_ack,
    output logic                        o_w_reg_we,
    output cpu_pkg::reg_addr_t          o_w_reg_addr,
    output logic [p_data_width-1:0]     o_w_reg_data,
    output logic                        o_w_retire,
    output logic                        o_w_res_req,
    output logic [p_data_width-1:0]     o_w_res_data,
    output cpu_pkg::flags_t             o_w_res_flags,
    output logic                        o_w_res_wrote,
    output cpu_pkg::reg_addr_t          o_w_res_reg,
    output logic                        o_w_res_illegal,
    output logic                        o_w_res_out
);

    import cpu_pkg::*;

    typedef enum logic [1:0] {
        l_p_st_idle,
        l_p_st_req,         // req high, waiting for ack
        l_p_st_drop         // req low, waiting for ack to fall
    } l_t_state;

    l_t_state l_r_state;

    // register file write lands on the edge after done
    assign o_w_reg_we   = i_w_done && i_w_wr_en;
    assign o_w_reg_addr = i_w_wr_addr;
    assign o_w_reg_data = i_w_result;

    always_ff @(posedge i_w_clk or negedge i_w_reset) begin
        if (!i_w_reset) begin
            l_r_state  <= l_p_st_idle;
            o_w_retire <= 1'b0;
        end else begin
            o_w_retire <= 1'b0;
            case (l_r_state)
                l_p_st_idle: begin
                    if (i_w_done) begin
                        l_r_state <= l_p_st_req;
                    end
                end
                l_p_st_req: begin
                    if (i_w_res_ack) begin
                        l_r_state <= l_p_st_drop;
                    end
                end
                default: begin
                    if (!i_w_res_ack) begin
                        l_r_state  <= l_p_st_idle;
                        o_w_retire <= 1'b1;             // frees the decoder
                    end
                end
            endcase
        end
    end

    assign o_w_res_req = (l_r_state == l_p_st_req);

    always_ff @(posedge i_w_clk) begin
        if (i_w_done) begin
            o_w_res_data    <= i_w_result;
            o_w_res_flags   <= i_w_flags;
            o_w_res_wrote   <= i_w_wr_en;
            o_w_res_reg     <= i_w_wr_addr;
            o_w_res_illegal <= i_w_illegal;
            o_w_res_out     <= i_w_out;
        end
    end

endmodule

/* cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
    parameter int p_data_width = 16
) (
    input  wire                                  i_w_clk,
    input  wire                                  i_w_reset,
    input  wire                                  i_w_instr_req,
    input  wire [cpu_pkg::instr_width-1:0]       i_w_instr,
    output logic                                 o_w_instr_ack,
    input  wire [p_data_width-1:0]               i_w_io_data,
    input  wire                                  i_w_res_ack,
    output logic                                 o_w_res_req,
    output logic [p_data_width-1:0]              o_w_res_data,
    output cpu_pkg::flags_t                      o_w_res_flags,
    output logic                                 o_w_res_wrote,
    output cpu_pkg::reg_addr_t                   o_w_res_reg,
    output logic                                 o_w_res_illegal,
    output logic                                 o_w_res_out
);

    import cpu_pkg::*;

    logic                       l_w_issue;
    alu_op_t                    l_w_alu_op;
    reg_addr_t                  l_w_rd_addr_a;
    reg_addr_t                  l_w_rd_addr_b;
    logic                       l_w_wr_en;
    reg_addr_t                  l_w_wr_addr;
    logic                       l_w_illegal;
    logic                       l_w_out;
    logic [p_data_width-1:0]    l_w_rd_data_a;
    logic [p_data_width-1:0]    l_w_rd_data_b;
    logic                       l_w_done;
    logic [p_data_width-1:0]    l_w_result;
    flags_t                     l_w_flags;
    logic                       l_w_reg_we;
    reg_addr_t                  l_w_reg_addr;
    logic [p_data_width-1:0]    l_w_reg_data;
    logic                       l_w_retire;

    instr_decode u_decode (
        .i_w_clk(i_w_clk), .i_w_reset(i_w_reset),
        .i_w_instr_req(i_w_instr_req), .i_w_instr(i_w_instr), .i_w_retire(l_w_retire),
        .o_w_instr_ack(o_w_instr_ack), .o_w_issue(l_w_issue), .o_w_alu_op(l_w_alu_op),
        .o_w_rd_addr_a(l_w_rd_addr_a), .o_w_rd_addr_b(l_w_rd_addr_b),
        .o_w_wr_en(l_w_wr_en), .o_w_wr_addr(l_w_wr_addr),
        .o_w_illegal(l_w_illegal), .o_w_out(l_w_out)
    );

    reg_file #(.p_data_width(p_data_width)) u_regs (
        .i_w_clk(i_w_clk), .i_w_reset(i_w_reset),
        .i_w_rd_addr_a(l_w_rd_addr_a), .i_w_rd_addr_b(l_w_rd_addr_b),
        .i_w_wr_en(l_w_reg_we), .i_w_wr_addr(l_w_reg_addr), .i_w_wr_data(l_w_reg_data),
        .o_w_rd_data_a(l_w_rd_data_a), .o_w_rd_data_b(l_w_rd_data_b)
    );

    alu_execute #(.p_data_width(p_data_width)) u_alu (
        .i_w_clk(i_w_clk), .i_w_reset(i_w_reset),
        .i_w_issue(l_w_issue), .i_w_alu_op(l_w_alu_op),
        .i_w_opd_a(l_w_rd_data_a), .i_w_opd_b(l_w_rd_data_b), .i_w_io_data(i_w_io_data),
        .o_w_done(l_w_done), .o_w_result(l_w_result), .o_w_flags(l_w_flags)
    );

    result_writeback #(.p_data_width(p_data_width)) u_wb (
        .i_w_clk(i_w_clk), .i_w_reset(i_w_reset),
        .i_w_done(l_w_done), .i_w_result(l_w_result), .i_w_flags(l_w_flags),
        .i_w_wr_en(l_w_wr_en), .i_w_wr_addr(l_w_wr_addr),
        .i_w_illegal(l_w_illegal), .i_w_out(l_w_out), .i_w_res_ack(i_w_res_ack),
        .o_w_reg_we(l_w_reg_we), .o_w_reg_addr(l_w_reg_addr), .o_w_reg_data(l_w_reg_data),
        .o_w_retire(l_w_retire), .o_w_res_req(o_w_res_req), .o_w_res_data(o_w_res_data),
        .o_w_res_flags(o_w_res_flags), .o_w_res_wrote(o_w_res_wrote),
        .o_w_res_reg(o_w_res_reg), .o_w_res_illegal(o_w_res_illegal),
        .o_w_res_out(o_w_res_out)
    );

endmodule

/* tb_cpu_model.svh */
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// shadow state with flags kept as {sign, zero, carry}
logic [15:0] m_regs [8];
logic [2:0]  m_flags;
logic [15:0] exp_data;
logic [2:0]  exp_flags;
logic        exp_wrote;
logic [2:0]  exp_reg;
logic        exp_illegal;
logic        exp_out;

// field value whose msb is the lowest word bit
function automatic logic [2:0] field3(input logic [15:0] w, input int lsb);
    return {w[lsb], w[lsb + 1], w[lsb + 2]};
endfunction

function automatic logic [15:0] encode(input logic [0:6] cop, input logic d,
                                       input logic [1:0] mode, input logic [2:0] rg,
                                       input logic [2:0] rm);
    logic [15:0] w;
    for (int i = 0; i < 7; i++) begin
        w[i] = cop[i];
    end
    w[7] = d;
    w[9:8] = {mode[0], mode[1]};
    w[12:10] = {rg[0], rg[1], rg[2]};
    w[15:13] = {rm[0], rm[1], rm[2]};
    return w;
endfunction

function automatic logic [15:0] enc_two(input logic [2:0] sel, input logic wr,
                                        input logic d, input logic [2:0] rg,
                                        input logic [2:0] rm);
    return encode({3'b010, wr, sel}, d, 2'b11, rg, rm);
endfunction

function automatic logic [15:0] enc_one(input logic [2:0] sel, input logic [2:0] rm);
    return encode({4'b0001, sel}, 1'b0, 2'b11, 3'd0, rm);
endfunction

function automatic logic [15:0] enc_io(input logic is_out);
    return encode({6'b100000, is_out}, 1'b0, 2'b11, 3'd0, 3'd0);
endfunction

// predicts every result port field and updates the shadows
task automatic model_step(input logic [15:0] w, input logic [15:0] io);
    logic [0:6]  cop;
    logic [2:0]  rg;
    logic [2:0]  rm;
    logic [2:0]  sel;
    logic [2:0]  dst;
    logic [15:0] a;
    logic [15:0] b;
    logic [16:0] t;
    logic        c;
    logic        mode_ok;
    for (int i = 0; i < 7; i++) begin
        cop[i] = w[i];
    end
    rg = field3(w, 10);
    rm = field3(w, 13);
    sel = cop[4:6];
    mode_ok = w[8] && w[9];
    exp_illegal = 1'b0;
    exp_out = 1'b0;
    exp_wrote = 1'b0;
    exp_reg = 3'd0;
    exp_data = m_regs[0];
    if (cop[0:3] == 4'b0001 && mode_ok && sel != 3'b111) begin
        a = m_regs[rm];
        case (sel)
            3'd0: t = {1'b0, a} + 17'd1;
            3'd1: t = {1'b0, a} - 17'd1;
            3'd2: t = {a != 16'd0, 16'd0 - a};
            3'd3: t = {1'b0, ~a};
            3'd4: t = {1'b0, a} << 1;
            3'd5: t = {a[0], a >> 1};
            default: t = {a[0], $signed(a) >>> 1};
        endcase
        exp_data = t[15:0];
        m_flags = {t[15], t[15:0] == 16'd0, t[16]};
        exp_wrote = 1'b1;
        exp_reg = rm;
    end else if (cop[0:2] == 3'b010 && mode_ok && sel != 3'b111) begin
        dst = w[7] ? rg : rm;
        a = m_regs[dst];
        b = m_regs[w[7] ? rm : rg];
        c = m_flags[0];
        case (sel)
            3'd0: t = {1'b0, a} + {1'b0, b};
            3'd1: t = {1'b0, a} + {1'b0, b} + {16'd0, c};
            3'd2: t = {1'b0, a} - {1'b0, b};
            3'd3: t = {1'b0, a} - {1'b0, b} - {16'd0, c};
            3'd4: t = {1'b0, a & b};
            3'd5: t = {1'b0, a | b};
            default: t = {1'b0, a ^ b};
        endcase
        exp_data = t[15:0];
        m_flags = {t[15], t[15:0] == 16'd0, t[16]};
        exp_wrote = cop[3];
        exp_reg = dst;
    end else if (cop[0:5] == 6'b100000) begin
        if (!cop[6]) begin
            exp_data = io;
            exp_wrote = 1'b1;
        end else begin
            exp_out = 1'b1;
        end
    end else begin
        exp_illegal = 1'b1;
    end
    if (exp_wrote) begin
        m_regs[exp_reg] = exp_data;
    end
    exp_flags = m_flags;
endtask

`endif

/* tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core;

    localparam int n_instr   = 404;               // instructions issued by all tests
    localparam int rst_len   = 16;
    localparam int cyc_limit = 40 * n_instr + rst_len;

    logic        i_w_clk;
    logic        i_w_reset;
    logic        i_w_instr_req;
    logic [15:0] i_w_instr;
    logic [15:0] i_w_io_data;
    logic        i_w_res_ack;
    logic        o_w_instr_ack;
    logic        o_w_res_req;
    logic [15:0] o_w_res_data;
    logic [2:0]  o_w_res_flags;
    logic        o_w_res_wrote;
    logic [2:0]  o_w_res_reg;
    logic        o_w_res_illegal;
    logic        o_w_res_out;

    integer seed = 32'h85579f56;
    int     cyc = 0;
    int     test_errs = 0;
    int     total_errs = 0;
    int     tests_run = 0;
    int     tests_bad = 0;
    string  test_name;

    `include "tb_cpu_model.svh"

    cpu_core #(.p_data_width(16)) u_dut (
        .i_w_clk(i_w_clk), .i_w_reset(i_w_reset),
        .i_w_instr_req(i_w_instr_req), .i_w_instr(i_w_instr), .o_w_instr_ack(o_w_instr_ack),
        .i_w_io_data(i_w_io_data), .i_w_res_ack(i_w_res_ack),
        .o_w_res_req(o_w_res_req), .o_w_res_data(o_w_res_data),
        .o_w_res_flags(o_w_res_flags), .o_w_res_wrote(o_w_res_wrote),
        .o_w_res_reg(o_w_res_reg), .o_w_res_illegal(o_w_res_illegal),
        .o_w_res_out(o_w_res_out)
    );

    initial begin
        i_w_clk = 1'b0;
        forever #2 i_w_clk = ~i_w_clk;
    end

    always @(posedge i_w_clk) begin
        cyc <= cyc + 1;
        if (cyc > cyc_limit) begin
            $display("run stopped: timeout after %0d cycles", cyc);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_val(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (exp == act) else begin
            $display("Fail %s %s: expected %h actual %h", test_name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            test_errs++;
        end
    endtask

    task automatic step();
        @(posedge i_w_clk);
        #1;
    endtask

    // one instruction through both ports
    // hold delays the result ack
    task automatic exec_instr(input logic [15:0] w, input logic [15:0] io, input int hold,
                              input logic pend);
        int          t_ack;
        logic [15:0] held;
        model_step(w, io);
        check_true(!o_w_instr_ack, "ack high before request");
        i_w_instr = w;
        i_w_io_data = io;
        i_w_instr_req = 1'b1;
        do step(); while (!o_w_instr_ack);
        t_ack = cyc;
        i_w_instr_req = 1'b0;
        do step(); while (o_w_instr_ack);
        while (!o_w_res_req) step();
        check_val("latency", 3, cyc - t_ack);
        check_val("data", exp_data, o_w_res_data);
        check_val("flags", exp_flags, o_w_res_flags);
        check_val("wrote", exp_wrote, o_w_res_wrote);
        if (exp_wrote) begin
            check_val("reg", exp_reg, o_w_res_reg);
        end
        check_val("illegal", exp_illegal, o_w_res_illegal);
        check_val("out", exp_out, o_w_res_out);
        held = o_w_res_data;
        if (pend) begin
            i_w_instr = enc_io(1'b1);            // next one waits behind this result
            i_w_instr_req = 1'b1;
        end
        for (int i = 0; i < hold; i++) begin
            step();
            check_true(o_w_res_req, "result request dropped before ack");
            check_true(o_w_res_data == held, "result data changed while waiting");
            check_true(!o_w_instr_ack, "instruction acknowledged before retire");
        end
        i_w_res_ack = 1'b1;
        do step(); while (o_w_res_req);
        i_w_res_ack = 1'b0;
    endtask

    task automatic load_reg(input logic [2:0] r, input logic [15:0] v, input logic d);
        exec_instr(enc_io(1'b0), v, 0, 1'b0);
        if (r != 3'd0) begin
            exec_instr(enc_two(3'd6, 1'b1, d, r, r), 16'h0, 0, 1'b0);
            if (d) begin
                exec_instr(enc_two(3'd5, 1'b1, 1'b1, r, 3'd0), 16'h0, 0, 1'b0);
            end else begin
                exec_instr(enc_two(3'd5, 1'b1, 1'b0, 3'd0, r), 16'h0, 0, 1'b0);
            end
        end
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errs);
            tests_bad++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        logic [15:0] edges [3];
        i_w_reset = 1'b0;
        i_w_instr_req = 1'b0;
        i_w_instr = 16'h0;
        i_w_io_data = 16'h0;
        i_w_res_ack = 1'b0;
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = 16'h0;
        end
        m_flags = 3'b000;
        edges[0] = 16'h0000;
        edges[1] = 16'hffff;
        edges[2] = 16'h8000;

        test_name = "reset";
        for (int i = 0; i < rst_len; i++) begin
            step();
            check_true(!o_w_instr_ack && !o_w_res_req, "port active during reset");
        end
        i_w_reset = 1'b1;
        step();
        check_true(!o_w_instr_ack && !o_w_res_req, "port active after reset");
        exec_instr(enc_io(1'b1), 16'h0, 0, 1'b0);
        end_test();

        test_name = "handshake";
        exec_instr(enc_io(1'b0), 16'h1234, ($random(seed) & 7) + 1, 1'b1);
        exec_instr(enc_io(1'b1), 16'h0, ($random(seed) & 7) + 1, 1'b0);
        end_test();

        test_name = "load";
        for (int r = 0; r < 8; r++) begin
            load_reg(r[2:0], 16'($random(seed)), r[0]);
            exec_instr(enc_two(3'd4, 1'b0, 1'b1, r[2:0], r[2:0]), 16'h0, 0, 1'b0);
        end
        exec_instr(enc_io(1'b1), 16'h0, 0, 1'b0);
        end_test();

        test_name = "two_operand";
        for (int k = 0; k < 4; k++) begin
            for (int s = 0; s < 7; s++) begin
                load_reg(3'd1, 16'($random(seed)), 1'b1);
                load_reg(3'd2, 16'($random(seed)), 1'b0);
                exec_instr(enc_two(s[2:0], 1'b1, k[0], 3'd1, 3'd2), 16'h0, 0, 1'b0);
                exec_instr(enc_two(s[2:0], 1'b0, k[1], 3'd2, 3'd1), 16'h0, 0, 1'b0);
                exec_instr(enc_two(s[2:0], 1'b1, k[0], 3'd2, 3'd1), 16'h0, 0, 1'b0);
            end
        end
        end_test();

        test_name = "one_operand";
        for (int s = 0; s < 7; s++) begin
            for (int e = 0; e < 4; e++) begin
                load_reg(3'd5, (e < 3) ? edges[e] : 16'($random(seed)), 1'b1);
                exec_instr(enc_one(s[2:0], 3'd5), 16'h0, 0, 1'b0);
            end
        end
        end_test();

        test_name = "illegal";
        exec_instr(encode(7'b0101000, 1'b1, 2'b10, 3'd1, 3'd2), 16'h0, 0, 1'b0);
        exec_instr(encode(7'b0000000, 1'b0, 2'b11, 3'd3, 3'd4), 16'h0, 0, 1'b0);
        exec_instr(enc_two(3'd7, 1'b1, 1'b1, 3'd1, 3'd2), 16'h0, 0, 1'b0);
        exec_instr(enc_one(3'd7, 3'd5), 16'h0, 0, 1'b0);
        exec_instr(enc_io(1'b1), 16'h0, 0, 1'b0);
        exec_instr(enc_two(3'd2, 1'b0, 1'b1, 3'd1, 3'd2), 16'h0, 0, 1'b0);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, total_errs);
        if (total_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
cpu_pkg.sv
instr_decode.sv
reg_file.sv
alu_execute.sv
result_writeback.sv
cpu_core.sv
tb_cpu_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu_core testbench with Verilator

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
        --top-module tb_cpu_core -o tb_sim; then
    echo "compile failed"
    exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation returned an error"
    exit 1
fi

cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1
